//--- rtl/ex_config.svh
// execute stage config: ISA-fixed widths shared by the package and the register file
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// RV64 integer data path width
`define EX_XLEN 64

// architectural integer register count
`define EX_NREGS 32

// index width into the register file
`define EX_RADDR_W 5

`endif

//--- rtl/ex_pkg.sv
// execute stage package: width typedefs and ALU/branch operation encodings
`include "ex_config.svh"

package ex_pkg;

  // data word, also used for pc and immediates
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // register index
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // alu operation, decode picks one per instruction
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_op2
  } alu_op_t;

  // branch kind, br_none for everything that does not redirect
  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } br_op_t;

endpackage

//--- rtl/gpr_file.sv
// gpr file: 32 x 64-bit integer registers, two async read ports, one sync write port
`timescale 1ns/1ps
`include "ex_config.svh"

module gpr_file (
  input  logic              clk,
  input  logic              rst,
  input  ex_pkg::reg_addr_t rs1_addr,
  input  ex_pkg::reg_addr_t rs2_addr,
  input  logic              wr,
  input  ex_pkg::reg_addr_t wr_addr,
  input  ex_pkg::xlen_t     wr_data,
  output ex_pkg::xlen_t     rs1_data,
  output ex_pkg::xlen_t     rs2_data
);
  import ex_pkg::*;

  xlen_t regs [`EX_NREGS];

  // x0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EX_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

//--- rtl/ex_forward.sv
// operand forwarding picks the newest value per source register and detects load-use hazards
`timescale 1ns/1ps

module ex_forward (
  input  ex_pkg::reg_addr_t rs1_addr,
  input  ex_pkg::reg_addr_t rs2_addr,
  input  logic              use_rs1,
  input  logic              use_rs2,
  input  ex_pkg::xlen_t     rf_rs1,
  input  ex_pkg::xlen_t     rf_rs2,
  input  logic              fwd_mem_valid,
  input  ex_pkg::reg_addr_t fwd_mem_addr,
  input  ex_pkg::xlen_t     fwd_mem_data,
  input  logic              fwd_mem_is_load,
  input  logic              wb_wr,
  input  ex_pkg::reg_addr_t wb_addr,
  input  ex_pkg::xlen_t     wb_data,
  output ex_pkg::xlen_t     rs1_fwd,
  output ex_pkg::xlen_t     rs2_fwd,
  output logic              hazard
);
  import ex_pkg::*;

  logic rs1_mem_hit;
  logic rs2_mem_hit;

  // memory stage first, then write-back, then the register file
  function automatic xlen_t pick(input reg_addr_t addr, input xlen_t rf_val);
    if (addr == '0) begin
      return '0;
    end else if (fwd_mem_valid && (fwd_mem_addr == addr)) begin
      return fwd_mem_data;
    end else if (wb_wr && (wb_addr == addr)) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs1_fwd = pick(rs1_addr, rf_rs1);
    rs2_fwd = pick(rs2_addr, rf_rs2);
  end

  // load data is not back yet when the load sits in memory
  assign rs1_mem_hit = use_rs1 && (rs1_addr != '0) && (fwd_mem_addr == rs1_addr);
  assign rs2_mem_hit = use_rs2 && (rs2_addr != '0) && (fwd_mem_addr == rs2_addr);
  assign hazard = fwd_mem_valid && fwd_mem_is_load && (rs1_mem_hit || rs2_mem_hit);

endmodule

//--- rtl/ex_alu.sv
// execute ALU: RV64 integer operations with 32-bit word mode
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::xlen_t   op1,
  input  ex_pkg::xlen_t   op2,
  input  ex_pkg::alu_op_t alu_op,
  input  logic            is_word,
  output ex_pkg::xlen_t   result
);
  import ex_pkg::*;

  logic [5:0]  shamt;
  logic [4:0]  shamt_w;
  logic [31:0] op1_w;
  logic [31:0] op2_w;
  xlen_t       res_d;
  logic [31:0] res_w;

  assign shamt   = op2[5:0];
  assign shamt_w = op2[4:0];
  assign op1_w   = op1[31:0];
  assign op2_w   = op2[31:0];

  // full 64-bit path
  always_comb begin
    case (alu_op)
      alu_add:      res_d = op1 + op2;
      alu_sub:      res_d = op1 - op2;
      alu_sll:      res_d = op1 << shamt;
      alu_slt:      res_d = xlen_t'($signed(op1) < $signed(op2));
      alu_sltu:     res_d = xlen_t'(op1 < op2);
      alu_xor:      res_d = op1 ^ op2;
      alu_srl:      res_d = op1 >> shamt;
      alu_sra:      res_d = $signed(op1) >>> shamt;
      alu_or:       res_d = op1 | op2;
      alu_and:      res_d = op1 & op2;
      alu_pass_op2: res_d = op2;
      default:      res_d = '0;
    endcase
  end

  // word path, shifts see only the low 32 bits of op1
  always_comb begin
    case (alu_op)
      alu_add:      res_w = op1_w + op2_w;
      alu_sub:      res_w = op1_w - op2_w;
      alu_sll:      res_w = op1_w << shamt_w;
      alu_slt:      res_w = 32'($signed(op1_w) < $signed(op2_w));
      alu_sltu:     res_w = 32'(op1_w < op2_w);
      alu_xor:      res_w = op1_w ^ op2_w;
      alu_srl:      res_w = op1_w >> shamt_w;
      alu_sra:      res_w = $signed(op1_w) >>> shamt_w;
      alu_or:       res_w = op1_w | op2_w;
      alu_and:      res_w = op1_w & op2_w;
      alu_pass_op2: res_w = op2_w;
      default:      res_w = '0;
    endcase
  end

  // *w results are sign-extended from bit 31
  assign result = is_word ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

//--- rtl/ex_branch.sv
// branch unit that evaluates the condition and forms the redirect target
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_branch (
  input  ex_pkg::br_op_t br_op,
  input  ex_pkg::xlen_t  rs1,
  input  ex_pkg::xlen_t  rs2,
  input  ex_pkg::xlen_t  pc,
  input  ex_pkg::xlen_t  imm,
  output logic           taken,
  output ex_pkg::xlen_t  target
);
  import ex_pkg::*;

  logic  eq;
  logic  lt;
  logic  ltu;
  xlen_t jalr_sum;

  assign eq  = (rs1 == rs2);
  assign lt  = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (br_op)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt;
      br_bge:  taken = !lt;
      br_bltu: taken = ltu;
      br_bgeu: taken = !ltu;
      br_jal,
      br_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // jalr clears bit 0 of the computed address
  assign jalr_sum = rs1 + imm;
  assign target = (br_op == br_jalr) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc + imm;

endmodule

//--- rtl/ex_stage.sv
// execute stage: stage register, valid/allowin handshake, operand select, ALU and branch
`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              id_valid,
  input  ex_pkg::xlen_t     id_pc,
  input  ex_pkg::xlen_t     id_op1,
  input  ex_pkg::xlen_t     id_op2,
  input  logic              id_use_rs1,
  input  logic              id_use_rs2,
  input  ex_pkg::reg_addr_t id_rs1_addr,
  input  ex_pkg::reg_addr_t id_rs2_addr,
  input  logic              id_is_word,
  input  ex_pkg::alu_op_t   id_alu_op,
  input  ex_pkg::br_op_t    id_br_op,
  input  ex_pkg::xlen_t     id_imm,
  input  ex_pkg::reg_addr_t id_rd_addr,
  input  logic              id_rd_wr,
  output logic              id_allowin,
  output logic              mem_valid,
  output ex_pkg::xlen_t     mem_pc,
  output ex_pkg::xlen_t     mem_result,
  output ex_pkg::xlen_t     mem_rs2_fwd,
  output ex_pkg::reg_addr_t mem_rd_addr,
  output logic              mem_rd_wr,
  input  logic              mem_allowin,
  input  logic              fwd_mem_valid,
  input  ex_pkg::reg_addr_t fwd_mem_addr,
  input  ex_pkg::xlen_t     fwd_mem_data,
  input  logic              fwd_mem_is_load,
  input  logic              wb_wr,
  input  ex_pkg::reg_addr_t wb_addr,
  input  ex_pkg::xlen_t     wb_data,
  output logic              redirect_valid,
  output logic              redirect_taken,
  output ex_pkg::xlen_t     redirect_pc,
  output ex_pkg::reg_addr_t rs1_addr,
  output ex_pkg::reg_addr_t rs2_addr,
  input  ex_pkg::xlen_t     rf_rs1,
  input  ex_pkg::xlen_t     rf_rs2
);
  import ex_pkg::*;

  logic      ex_valid;
  logic      ready_go;
  logic      hazard;

  // latched instruction fields
  xlen_t     pc_q;
  xlen_t     op1_q;
  xlen_t     op2_q;
  logic      use_rs1_q;
  logic      use_rs2_q;
  reg_addr_t rs1_addr_q;
  reg_addr_t rs2_addr_q;
  logic      is_word_q;
  alu_op_t   alu_op_q;
  br_op_t    br_op_q;
  xlen_t     imm_q;
  reg_addr_t rd_addr_q;
  logic      rd_wr_q;

  xlen_t     rs1_fwd;
  xlen_t     rs2_fwd;
  xlen_t     alu_op1;
  xlen_t     alu_op2;

  // only a load-use hazard holds the instruction
  assign ready_go   = !hazard;
  assign id_allowin = !ex_valid || (ready_go && mem_allowin);
  assign mem_valid  = ex_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (id_allowin) begin
      ex_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid && id_allowin) begin
      pc_q       <= id_pc;
      op1_q      <= id_op1;
      op2_q      <= id_op2;
      use_rs1_q  <= id_use_rs1;
      use_rs2_q  <= id_use_rs2;
      rs1_addr_q <= id_rs1_addr;
      rs2_addr_q <= id_rs2_addr;
      is_word_q  <= id_is_word;
      alu_op_q   <= id_alu_op;
      br_op_q    <= id_br_op;
      imm_q      <= id_imm;
      rd_addr_q  <= id_rd_addr;
      rd_wr_q    <= id_rd_wr;
    end
  end

  // register file is read with the latched source indices
  assign rs1_addr = rs1_addr_q;
  assign rs2_addr = rs2_addr_q;

  ex_forward u_forward (
    .rs1_addr        (rs1_addr_q),
    .rs2_addr        (rs2_addr_q),
    .use_rs1         (use_rs1_q),
    .use_rs2         (use_rs2_q),
    .rf_rs1          (rf_rs1),
    .rf_rs2          (rf_rs2),
    .fwd_mem_valid   (fwd_mem_valid),
    .fwd_mem_addr    (fwd_mem_addr),
    .fwd_mem_data    (fwd_mem_data),
    .fwd_mem_is_load (fwd_mem_is_load),
    .wb_wr           (wb_wr),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .rs1_fwd         (rs1_fwd),
    .rs2_fwd         (rs2_fwd),
    .hazard          (hazard)
  );

  // decode supplies pc and 4 for jumps, so the link value is an add
  assign alu_op1 = use_rs1_q ? rs1_fwd : op1_q;
  assign alu_op2 = use_rs2_q ? rs2_fwd : op2_q;

  ex_alu u_alu (
    .op1     (alu_op1),
    .op2     (alu_op2),
    .alu_op  (alu_op_q),
    .is_word (is_word_q),
    .result  (mem_result)
  );

  ex_branch u_branch (
    .br_op  (br_op_q),
    .rs1    (rs1_fwd),
    .rs2    (rs2_fwd),
    .pc     (pc_q),
    .imm    (imm_q),
    .taken  (redirect_taken),
    .target (redirect_pc)
  );

  assign redirect_valid = mem_valid && (br_op_q != br_none);

  assign mem_pc      = pc_q;
  assign mem_rs2_fwd = rs2_fwd;
  assign mem_rd_addr = rd_addr_q;
  assign mem_rd_wr   = rd_wr_q;

endmodule

//--- rtl/ex_top.sv
// execute top: execute stage joined to the integer register file
`timescale 1ns/1ps

module ex_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              id_valid,
  input  ex_pkg::xlen_t     id_pc,
  input  ex_pkg::xlen_t     id_op1,
  input  ex_pkg::xlen_t     id_op2,
  input  logic              id_use_rs1,
  input  logic              id_use_rs2,
  input  ex_pkg::reg_addr_t id_rs1_addr,
  input  ex_pkg::reg_addr_t id_rs2_addr,
  input  logic              id_is_word,
  input  ex_pkg::alu_op_t   id_alu_op,
  input  ex_pkg::br_op_t    id_br_op,
  input  ex_pkg::xlen_t     id_imm,
  input  ex_pkg::reg_addr_t id_rd_addr,
  input  logic              id_rd_wr,
  output logic              id_allowin,
  output logic              mem_valid,
  output ex_pkg::xlen_t     mem_pc,
  output ex_pkg::xlen_t     mem_result,
  output ex_pkg::xlen_t     mem_rs2_fwd,
  output ex_pkg::reg_addr_t mem_rd_addr,
  output logic              mem_rd_wr,
  input  logic              mem_allowin,
  input  logic              fwd_mem_valid,
  input  ex_pkg::reg_addr_t fwd_mem_addr,
  input  ex_pkg::xlen_t     fwd_mem_data,
  input  logic              fwd_mem_is_load,
  input  logic              wb_wr,
  input  ex_pkg::reg_addr_t wb_addr,
  input  ex_pkg::xlen_t     wb_data,
  output logic              redirect_valid,
  output logic              redirect_taken,
  output ex_pkg::xlen_t     redirect_pc
);
  import ex_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rf_rs1;
  xlen_t     rf_rs2;

  ex_stage u_ex_stage (
    .clk             (clk),
    .rst             (rst),
    .id_valid        (id_valid),
    .id_pc           (id_pc),
    .id_op1          (id_op1),
    .id_op2          (id_op2),
    .id_use_rs1      (id_use_rs1),
    .id_use_rs2      (id_use_rs2),
    .id_rs1_addr     (id_rs1_addr),
    .id_rs2_addr     (id_rs2_addr),
    .id_is_word      (id_is_word),
    .id_alu_op       (id_alu_op),
    .id_br_op        (id_br_op),
    .id_imm          (id_imm),
    .id_rd_addr      (id_rd_addr),
    .id_rd_wr        (id_rd_wr),
    .id_allowin      (id_allowin),
    .mem_valid       (mem_valid),
    .mem_pc          (mem_pc),
    .mem_result      (mem_result),
    .mem_rs2_fwd     (mem_rs2_fwd),
    .mem_rd_addr     (mem_rd_addr),
    .mem_rd_wr       (mem_rd_wr),
    .mem_allowin     (mem_allowin),
    .fwd_mem_valid   (fwd_mem_valid),
    .fwd_mem_addr    (fwd_mem_addr),
    .fwd_mem_data    (fwd_mem_data),
    .fwd_mem_is_load (fwd_mem_is_load),
    .wb_wr           (wb_wr),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .redirect_valid  (redirect_valid),
    .redirect_taken  (redirect_taken),
    .redirect_pc     (redirect_pc),
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rf_rs1          (rf_rs1),
    .rf_rs2          (rf_rs2)
  );

  // write-back port shares the forwarding wires
  gpr_file u_gpr_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr       (wb_wr),
    .wr_addr  (wb_addr),
    .wr_data  (wb_data),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

endmodule

//--- dv/tb_ex_top.sv
// directed testbench for the execute stage top level
`timescale 1ns/1ps

module tb_ex_top;
  import ex_pkg::*;

  localparam int num_tests       = 6;
  localparam int cycles_per_test = 200;
  localparam int wait_limit      = 20;

  logic      clk;
  logic      rst;
  logic      id_valid;
  xlen_t     id_pc;
  xlen_t     id_op1;
  xlen_t     id_op2;
  logic      id_use_rs1;
  logic      id_use_rs2;
  reg_addr_t id_rs1_addr;
  reg_addr_t id_rs2_addr;
  logic      id_is_word;
  alu_op_t   id_alu_op;
  br_op_t    id_br_op;
  xlen_t     id_imm;
  reg_addr_t id_rd_addr;
  logic      id_rd_wr;
  logic      id_allowin;
  logic      mem_valid;
  xlen_t     mem_pc;
  xlen_t     mem_result;
  xlen_t     mem_rs2_fwd;
  reg_addr_t mem_rd_addr;
  logic      mem_rd_wr;
  logic      mem_allowin;
  logic      fwd_mem_valid;
  reg_addr_t fwd_mem_addr;
  xlen_t     fwd_mem_data;
  logic      fwd_mem_is_load;
  logic      wb_wr;
  reg_addr_t wb_addr;
  xlen_t     wb_data;
  logic      redirect_valid;
  logic      redirect_taken;
  xlen_t     redirect_pc;

  integer seed = 32'h7c54becb;
  int     err_count;
  int     check_count;
  int     tests_run;

  ex_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stop a hung run
  initial begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", num_tests * cycles_per_test);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic xlen_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // expected ALU result from the RV64 rules
  function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b,
                                      input logic word);
    xlen_t       r;
    logic [31:0] aw;
    logic [31:0] bw;
    logic [31:0] rw;
    aw = a[31:0];
    bw = b[31:0];
    r  = '0;
    rw = '0;
    if (word) begin
      case (op)
        alu_add: rw = aw + bw;
        alu_sub: rw = aw - bw;
        alu_sll: rw = aw << bw[4:0];
        alu_srl: rw = aw >> bw[4:0];
        alu_sra: rw = $signed(aw) >>> bw[4:0];
        default: rw = '0;
      endcase
      r = {{32{rw[31]}}, rw};
    end else begin
      case (op)
        alu_add:      r = a + b;
        alu_sub:      r = a + ~b + 64'd1;
        alu_sll:      r = a << b[5:0];
        alu_slt:      r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        alu_sltu:     r = (a < b) ? 64'd1 : 64'd0;
        alu_xor:      r = a ^ b;
        alu_srl:      r = a >> b[5:0];
        alu_sra:      r = $signed(a) >>> b[5:0];
        alu_or:       r = a | b;
        alu_and:      r = a & b;
        alu_pass_op2: r = b;
        default:      r = '0;
      endcase
    end
    return r;
  endfunction

  function automatic logic br_model(input br_op_t op, input xlen_t a, input xlen_t b);
    case (op)
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      br_bgeu: return a >= b;
      br_jal,
      br_jalr: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_raddr(input string name, input reg_addr_t got, input reg_addr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("error: %s", msg);
  endtask

  task automatic log_test_end(input string name, input int e0);
    tests_run++;
    $display("test %s finished with %0d errors", name, err_count - e0);
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic init_inputs();
    rst             = 1'b1;
    id_valid        = 1'b0;
    id_pc           = '0;
    id_op1          = '0;
    id_op2          = '0;
    id_use_rs1      = 1'b0;
    id_use_rs2      = 1'b0;
    id_rs1_addr     = '0;
    id_rs2_addr     = '0;
    id_is_word      = 1'b0;
    id_alu_op       = alu_add;
    id_br_op        = br_none;
    id_imm          = '0;
    id_rd_addr      = '0;
    id_rd_wr        = 1'b0;
    mem_allowin     = 1'b1;
    fwd_mem_valid   = 1'b0;
    fwd_mem_addr    = '0;
    fwd_mem_data    = '0;
    fwd_mem_is_load = 1'b0;
    wb_wr           = 1'b0;
    wb_addr         = '0;
    wb_data         = '0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input xlen_t data);
    next_cycle();
    wb_wr   = 1'b1;
    wb_addr = addr;
    wb_data = data;
    next_cycle();
    wb_wr   = 1'b0;
  endtask

  task automatic drive_instr(input alu_op_t aop, input br_op_t bop, input logic word,
                             input logic u1, input reg_addr_t r1, input logic u2,
                             input reg_addr_t r2, input xlen_t op1, input xlen_t op2,
                             input xlen_t pc, input xlen_t imm, input reg_addr_t rd);
    id_valid    = 1'b1;
    id_alu_op   = aop;
    id_br_op    = bop;
    id_is_word  = word;
    id_use_rs1  = u1;
    id_rs1_addr = r1;
    id_use_rs2  = u2;
    id_rs2_addr = r2;
    id_op1      = op1;
    id_op2      = op2;
    id_pc       = pc;
    id_imm      = imm;
    id_rd_addr  = rd;
    id_rd_wr    = (rd != '0);
  endtask

  // returns 1 ns after the accepting edge with id_valid dropped
  task automatic wait_accept();
    int n;
    n = 0;
    #2;
    while (!id_allowin && n < wait_limit) begin
      next_cycle();
      #2;
      n++;
    end
    if (!id_allowin) begin
      report_error("instruction was not accepted in time");
    end
    next_cycle();
    id_valid = 1'b0;
  endtask

  // returns late in the cycle in which the instruction leaves
  task automatic wait_leave(output int waited);
    waited = 0;
    #2;
    while (!(mem_valid && mem_allowin) && waited < wait_limit) begin
      next_cycle();
      #2;
      waited++;
    end
    if (!(mem_valid && mem_allowin)) begin
      report_error("instruction never left the execute stage");
    end
  endtask

  task automatic alu_op_sweep();
    int      e0;
    int      waited;
    alu_op_t aop;
    xlen_t   a;
    xlen_t   b;
    e0 = err_count;
    check_bit("mem_valid", mem_valid, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    check_bit("id_allowin", id_allowin, 1'b1);
    aop = aop.first();
    do begin
      a = rand64();
      b = rand64();
      write_reg(5'd5, a);
      write_reg(5'd6, b);
      next_cycle();
      drive_instr(aop, br_none, 1'b0, 1'b1, 5'd5, 1'b1, 5'd6, '0, '0, 64'h100, '0, 5'd7);
      wait_accept();
      wait_leave(waited);
      if (waited != 0) begin
        report_error($sformatf("%s result came %0d cycles late", aop.name(), waited));
      end
      check_xlen("mem_result", mem_result, alu_model(aop, a, b, 1'b0));
      check_xlen("mem_rs2_fwd", mem_rs2_fwd, b);
      check_raddr("mem_rd_addr", mem_rd_addr, 5'd7);
      check_bit("mem_rd_wr", mem_rd_wr, 1'b1);
      aop = aop.next();
    end while (aop != aop.first());
    log_test_end("alu_ops", e0);
  endtask

  task automatic word_op_sweep();
    int      e0;
    int      waited;
    alu_op_t ops [5];
    xlen_t   a;
    xlen_t   b;
    e0  = err_count;
    ops = '{alu_add, alu_sub, alu_sll, alu_srl, alu_sra};
    foreach (ops[i]) begin
      for (int s = 0; s < 2; s++) begin
        a = rand64();
        b = rand64();
        // both signs of the low word
        a[31] = (s == 1);
        next_cycle();
        drive_instr(ops[i], br_none, 1'b1, 1'b0, 5'd0, 1'b0, 5'd0, a, b, 64'h180, '0, 5'd8);
        wait_accept();
        wait_leave(waited);
        check_xlen("mem_result", mem_result, alu_model(ops[i], a, b, 1'b1));
      end
    end
    log_test_end("word_ops", e0);
  endtask

  task automatic forward_priority();
    int    e0;
    int    waited;
    xlen_t rf_val;
    xlen_t mem_val;
    xlen_t wb_val;
    e0      = err_count;
    rf_val  = rand64();
    mem_val = rand64();
    wb_val  = rand64();
    write_reg(5'd9, rf_val);
    next_cycle();
    // hold the instruction in EX while the sources change
    mem_allowin   = 1'b0;
    fwd_mem_valid = 1'b1;
    fwd_mem_addr  = 5'd9;
    fwd_mem_data  = mem_val;
    drive_instr(alu_add, br_none, 1'b0, 1'b1, 5'd9, 1'b0, 5'd0, '0, '0, 64'h200, '0, 5'd10);
    wait_accept();
    // an older write-back to the same register lands at the next edge
    wb_wr   = 1'b1;
    wb_addr = 5'd9;
    wb_data = rand64();
    #2;
    check_xlen("mem_result", mem_result, mem_val);
    next_cycle();
    fwd_mem_valid = 1'b0;
    wb_data       = wb_val;
    #2;
    check_xlen("mem_result", mem_result, wb_val);
    next_cycle();
    wb_wr = 1'b0;
    #2;
    // write-back has landed in the register file by now
    check_xlen("mem_result", mem_result, wb_val);
    next_cycle();
    mem_allowin   = 1'b1;
    fwd_mem_valid = 1'b1;
    fwd_mem_addr  = 5'd0;
    fwd_mem_data  = rand64();
    wb_wr         = 1'b1;
    wb_addr       = 5'd0;
    wb_data       = rand64();
    next_cycle();
    drive_instr(alu_or, br_none, 1'b0, 1'b1, 5'd0, 1'b1, 5'd0, '0, '0, 64'h204, '0, 5'd10);
    wait_accept();
    wait_leave(waited);
    check_xlen("mem_result", mem_result, '0);
    check_xlen("mem_rs2_fwd", mem_rs2_fwd, '0);
    next_cycle();
    fwd_mem_valid = 1'b0;
    wb_wr         = 1'b0;
    log_test_end("forwarding", e0);
  endtask

  task automatic load_use_stall();
    int    e0;
    int    waited;
    xlen_t ld_val;
    xlen_t c;
    e0     = err_count;
    ld_val = rand64();
    c      = rand64();
    write_reg(5'd11, rand64());
    next_cycle();
    fwd_mem_valid   = 1'b1;
    fwd_mem_addr    = 5'd11;
    fwd_mem_data    = rand64();
    fwd_mem_is_load = 1'b1;
    drive_instr(alu_add, br_none, 1'b0, 1'b1, 5'd11, 1'b0, 5'd0, '0, c, 64'h300, '0, 5'd12);
    wait_accept();
    repeat (3) begin
      #2;
      check_bit("mem_valid", mem_valid, 1'b0);
      check_bit("id_allowin", id_allowin, 1'b0);
      next_cycle();
    end
    // load data now available from memory
    fwd_mem_is_load = 1'b0;
    fwd_mem_data    = ld_val;
    wait_leave(waited);
    check_xlen("mem_result", mem_result, ld_val + c);
    next_cycle();
    fwd_mem_valid = 1'b0;
    log_test_end("load_use", e0);
  endtask

  task automatic back_pressure_hold();
    int    e0;
    xlen_t a;
    xlen_t b;
    e0 = err_count;
    a  = rand64();
    b  = rand64();
    next_cycle();
    mem_allowin = 1'b0;
    drive_instr(alu_xor, br_none, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, a, b, 64'h400, '0, 5'd13);
    wait_accept();
    // second instruction waits upstream
    drive_instr(alu_sub, br_none, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, b, a, 64'h404, '0, 5'd14);
    repeat (4) begin
      #2;
      check_bit("mem_valid", mem_valid, 1'b1);
      check_xlen("mem_result", mem_result, a ^ b);
      check_raddr("mem_rd_addr", mem_rd_addr, 5'd13);
      check_xlen("mem_pc", mem_pc, 64'h400);
      check_bit("id_allowin", id_allowin, 1'b0);
      next_cycle();
    end
    mem_allowin = 1'b1;
    #2;
    check_bit("id_allowin", id_allowin, 1'b1);
    check_xlen("mem_result", mem_result, a ^ b);
    next_cycle();
    id_valid = 1'b0;
    #2;
    check_bit("mem_valid", mem_valid, 1'b1);
    check_xlen("mem_result", mem_result, b - a);
    check_raddr("mem_rd_addr", mem_rd_addr, 5'd14);
    check_xlen("mem_pc", mem_pc, 64'h404);
    log_test_end("back_pressure", e0);
  endtask

  task automatic branch_redirect();
    int        e0;
    int        waited;
    br_op_t    bop;
    reg_addr_t r1 [3];
    reg_addr_t r2 [3];
    xlen_t     v1 [3];
    xlen_t     v2 [3];
    xlen_t     eq_val;
    xlen_t     neg_val;
    xlen_t     pos_val;
    xlen_t     pc;
    xlen_t     imm;
    xlen_t     base;
    logic      exp_taken;
    e0      = err_count;
    eq_val  = rand64();
    neg_val = rand64() | 64'h8000_0000_0000_0000;
    pos_val = rand64() & 64'h7fff_ffff_ffff_ffff;
    base    = 64'h0000_0000_8000_3001;
    pc      = 64'h0000_0000_8000_1000;
    imm     = 64'hffff_ffff_ffff_ffe0;
    write_reg(5'd12, eq_val);
    write_reg(5'd13, eq_val);
    write_reg(5'd14, neg_val);
    write_reg(5'd15, pos_val);
    write_reg(5'd16, base);
    // equal, negative against positive, positive against negative
    r1 = '{5'd12, 5'd14, 5'd15};
    r2 = '{5'd13, 5'd15, 5'd14};
    v1 = '{eq_val, neg_val, pos_val};
    v2 = '{eq_val, pos_val, neg_val};
    bop = br_beq;
    while (bop != br_jal) begin
      for (int p = 0; p < 3; p++) begin
        next_cycle();
        drive_instr(alu_add, bop, 1'b0, 1'b1, r1[p], 1'b1, r2[p], '0, '0, pc, imm, 5'd0);
        wait_accept();
        wait_leave(waited);
        exp_taken = br_model(bop, v1[p], v2[p]);
        check_bit("redirect_valid", redirect_valid, 1'b1);
        check_bit("redirect_taken", redirect_taken, exp_taken);
        if (exp_taken) begin
          check_xlen("redirect_pc", redirect_pc, pc + imm);
        end
      end
      bop = bop.next();
    end
    next_cycle();
    drive_instr(alu_add, br_none, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, 64'h1, 64'h2, pc, '0, 5'd3);
    wait_accept();
    wait_leave(waited);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    // jal links pc plus 4 through the ALU
    next_cycle();
    drive_instr(alu_add, br_jal, 1'b0, 1'b0, 5'd0, 1'b0, 5'd0, pc, 64'd4, pc, 64'h800, 5'd1);
    wait_accept();
    wait_leave(waited);
    check_bit("redirect_valid", redirect_valid, 1'b1);
    check_bit("redirect_taken", redirect_taken, 1'b1);
    check_xlen("redirect_pc", redirect_pc, pc + 64'h800);
    check_xlen("mem_result", mem_result, pc + 64'd4);
    next_cycle();
    drive_instr(alu_add, br_jalr, 1'b0, 1'b0, 5'd16, 1'b0, 5'd0, pc, 64'd4, pc, 64'h10, 5'd1);
    wait_accept();
    wait_leave(waited);
    check_bit("redirect_valid", redirect_valid, 1'b1);
    check_bit("redirect_taken", redirect_taken, 1'b1);
    check_xlen("redirect_pc", redirect_pc, (base + 64'h10) & ~64'h1);
    check_xlen("mem_result", mem_result, pc + 64'd4);
    log_test_end("branches", e0);
  endtask

  initial begin
    err_count   = 0;
    check_count = 0;
    tests_run   = 0;
    init_inputs();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    alu_op_sweep();
    word_op_sweep();
    forward_priority();
    load_use_stall();
    back_pressure_hold();
    branch_redirect();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/gpr_file.sv
rtl/ex_forward.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_stage.sv
rtl/ex_top.sv
dv/tb_ex_top.sv

//--- Makefile
TOP := tb_ex_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

# pass only when the pass line shows up in the output
sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir
